/* dv/pru_chk.sv */
`default_nettype none

module pru_chk (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       i_psel,
    input wire logic       i_penable,
    input wire logic       i_pslverr,
    input wire logic       i_scan_start,
    input wire logic       i_go,
    input wire logic       i_lane_ack,
    input wire logic       i_pix_valid,
    input wire logic       i_pix_ready,
    input wire logic       i_pix_last,
    input wire logic [9:0] i_red,
    input wire logic [9:0] i_green,
    input wire logic [9:0] i_blue
);

    logic drawing;  // Busy is go or drawing

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            drawing <= 1'b0;
        else if (i_go)
            drawing <= 1'b1;
        else if (i_lane_ack)
            drawing <= 1'b0;
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_pix_valid && !i_pix_ready |=> i_pix_valid && $stable(i_pix_last) &&
            $stable(i_red) && $stable(i_green) && $stable(i_blue))
        else $error("pixel stream changed while stalled");

    // Access phase follows exactly one setup cycle
    a_err_phase: assert property (@(posedge clk) disable iff (!rst_n)
        i_pslverr |-> i_psel && i_penable && $past(i_psel && !i_penable))
        else $error("pslverr outside an access phase");

    a_scan_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_scan_start |-> !(i_go || drawing))
        else $error("scan started during a draw");

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        i_pix_last |-> i_pix_valid)
        else $error("last flag without valid");

endmodule

bind pru_top pru_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pslverr    (o_pslverr),
    .i_scan_start (i_scan_start),
    .i_go         (go),
    .i_lane_ack   (lane_ack),
    .i_pix_valid  (o_pix_valid),
    .i_pix_ready  (i_pix_ready),
    .i_pix_last   (o_pix_last),
    .i_red        (o_red),
    .i_green      (o_green),
    .i_blue       (o_blue)
);

`default_nettype wire

/* dv/pru_tb.sv */
`default_nettype none

`include "pru_settings.svh"

module pru_tb
    import pru_pkg::*;
();

    localparam int GRID       = `PRU_GRID;
    localparam int NPIX       = GRID * GRID;
    localparam int N_ENTRIES  = 5;
    localparam int N_TESTS    = N_ENTRIES + 2;
    localparam int BOX_CYCLES = 320;    // Full strip walk plus register traffic
    localparam int WATCHDOG   = N_TESTS * (NPIX + BOX_CYCLES) * 4 * 2;
    localparam logic [29:0] GREY = {3{10'h200}};
    localparam logic [29:0] PAL_SET [4] = '{30'h0, 30'h3FF0_0000, 30'h000F_FC00, 30'h3FF};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        scan_start, pix_ready;
    logic        pix_valid, pix_last;
    logic [9:0]  red, green, blue;

    logic [1:0]  grid [GRID][GRID];     // Reference colour map
    logic [29:0] pal [4];
    logic [15:0] lfsr = 16'd9;
    int          err_count, check_count, test_count, test_fails;

    // Stimulus table with the hand count of pixels in each shape's colour
    pru_shape_u  tbl_shape [N_ENTRIES];
    logic [5:0]  tbl_row [N_ENTRIES];
    logic [5:0]  tbl_col [N_ENTRIES];
    int          tbl_count [N_ENTRIES];
    string       tbl_name [N_ENTRIES];

    always #2 clk = ~clk;

    pru_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .o_prdata     (prdata),
        .o_pslverr    (pslverr),
        .i_scan_start (scan_start),
        .o_pix_valid  (pix_valid),
        .i_pix_ready  (pix_ready),
        .o_pix_last   (pix_last),
        .o_red        (red),
        .o_green      (green),
        .o_blue       (blue)
    );

    // Galois LFSR stepped once per bit
    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    function automatic pru_shape_u rect_shape(input logic [1:0] colour, input logic [5:0] h,
                                              input logic [5:0] w);
        pru_shape_u s;
        s             = '0;
        s.rect.colour = colour;
        s.rect.kind   = KIND_RECT;
        s.rect.height = h;
        s.rect.width  = w;
        return s;
    endfunction

    function automatic pru_shape_u circle_shape(input logic [1:0] colour, input logic [5:0] r);
        pru_shape_u s;
        s             = '0;
        s.circ.colour = colour;
        s.circ.kind   = KIND_CIRCLE;
        s.circ.radius = r;
        return s;
    endfunction

    task automatic set_entry(input int i, input pru_shape_u s, input logic [5:0] row,
                             input logic [5:0] col, input int count, input string name);
        tbl_shape[i] = s;
        tbl_row[i]   = row;
        tbl_col[i]   = col;
        tbl_count[i] = count;
        tbl_name[i]  = name;
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fails++;
            $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
        end
    endtask

    // Setup phase then access phase with the response sampled mid access
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_eq(err, 1'b0, "pslverr on a mapped write");
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_eq(err, 1'b0, "pslverr on a mapped read");
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        rd = 32'd1;
        while (rd[0])
            apb_read(`PRU_ADDR_CTRL, rd);
    endtask

    // Later shapes overwrite earlier ones and off-grid pixels are simply skipped
    task automatic model_draw(input int i);
        int         r, c, r0, c0, dr, dc, size_h, size_w, rad;
        logic       hit;
        pru_shape_u s;
        s      = tbl_shape[i];
        r0     = $signed(tbl_row[i]);
        c0     = $signed(tbl_col[i]);
        size_h = s.rect.height;
        size_w = s.rect.width;
        rad    = s.circ.radius;
        for (r = 0; r < GRID; r++) begin
            for (c = 0; c < GRID; c++) begin
                dr = r - r0;
                dc = c - c0;
                case (s.rect.kind)
                    KIND_RECT:   hit = dr >= 0 && dr < size_h && dc >= 0 && dc < size_w;
                    KIND_CIRCLE: hit = dr * dr + dc * dc <= rad * rad;
                    KIND_CLEAR:  hit = 1'b1;
                    default:     hit = 1'b0;
                endcase
                if (hit)
                    grid[r][c] = (s.rect.kind == KIND_CLEAR) ? 2'd0 : s.rect.colour;
            end
        end
    endtask

    task automatic scan_and_check(input logic [29:0] count_rgb, output int hits);
        int          n;
        logic        b0, b1;
        logic [29:0] exp_rgb;
        n    = 0;
        hits = 0;
        @(posedge clk);
        scan_start <= 1'b1;
        @(posedge clk);
        scan_start <= 1'b0;
        while (n < NPIX) begin
            b0 = rand_bit();
            b1 = rand_bit();
            pix_ready <= b0 | b1;      // Ready about three cycles in four
            @(negedge clk);
            if (pix_valid && pix_ready) begin
                exp_rgb = pal[grid[n / GRID][n % GRID]];
                check_eq({red, green, blue}, exp_rgb, $sformatf("pixel %0d", n));
                check_eq(pix_last, n == NPIX - 1, $sformatf("last flag on pixel %0d", n));
                if ({red, green, blue} == count_rgb)
                    hits++;
                n++;
            end
            @(posedge clk);
        end
        pix_ready <= 1'b0;
        repeat (4) @(negedge clk);
        check_eq(pix_valid, 1'b0, "stream idle after the last pixel");
    endtask

    initial begin
        int          errs, hits;
        logic [31:0] rd;
        logic        err;
        logic [1:0]  colour;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'd0;
        pwdata     = 32'd0;
        scan_start = 1'b0;
        pix_ready  = 1'b0;
        foreach (pal[i])
            pal[i] = GREY;
        foreach (grid[r, c])
            grid[r][c] = 2'd0;
        set_entry(0, rect_shape(2'd1, 6'd12, 6'd12), 6'h3D, 6'd24, 72, "rect clipped top right");
        set_entry(1, circle_shape(2'd2, 6'd5), 6'd6, 6'd22, 81, "circle over rect");
        set_entry(2, circle_shape(2'd3, 6'd3), 6'd30, 6'd30, 18, "circle clipped corner");
        set_entry(3, pru_shape_u'({28'd0, KIND_CLEAR, 2'd0}), 6'd0, 6'd0, NPIX, "clear");
        set_entry(4, rect_shape(2'd3, 6'd8, 6'd6), 6'd24, 6'h3E, 32, "rect clipped left");
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Power-up clear, then the reset grey everywhere
        errs = err_count;
        wait_idle();
        scan_and_check(GREY, hits);
        check_eq(hits, NPIX, "grey pixels after reset");
        report_test("reset scan", errs);

        errs = err_count;
        apb_read(`PRU_ADDR_CTRL, rd);
        check_eq(rd, 32'd0, "CTRL after the power-up clear");
        for (int i = 0; i < 4; i++) begin
            apb_write(`PRU_ADDR_PAL0 + 8'(4 * i), {2'b11, PAL_SET[i]});
            pal[i] = PAL_SET[i];
        end
        apb_write(`PRU_ADDR_SHAPE, 32'h0000_5A5A);
        apb_access(1'b1, 8'h0C, 32'hFFFF_FFFF, rd, err);
        check_eq(err, 1'b1, "pslverr on an unmapped write");
        apb_access(1'b0, 8'h24, 32'd0, rd, err);
        check_eq(err, 1'b1, "pslverr on an unmapped read");
        for (int i = 0; i < 4; i++) begin
            apb_read(`PRU_ADDR_PAL0 + 8'(4 * i), rd);
            check_eq(rd, pal[i], $sformatf("palette %0d readback", i));
        end
        apb_read(`PRU_ADDR_SHAPE, rd);
        check_eq(rd, 32'h0000_5A5A, "shape readback");
        apb_read(`PRU_ADDR_ORIGIN, rd);
        check_eq(rd, 32'd0, "origin unchanged by the unmapped write");
        report_test("register access", errs);

        for (int i = 0; i < N_ENTRIES; i++) begin
            errs = err_count;
            apb_write(`PRU_ADDR_SHAPE, tbl_shape[i]);
            apb_write(`PRU_ADDR_ORIGIN, {18'd0, tbl_row[i], 2'd0, tbl_col[i]});
            apb_write(`PRU_ADDR_CTRL, 32'd1);
            model_draw(i);
            apb_read(`PRU_ADDR_CTRL, rd);
            check_eq(rd, 32'd1, "busy set and done cleared by start");
            apb_write(`PRU_ADDR_CTRL, 32'd1);     // Lands while busy
            wait_idle();
            apb_read(`PRU_ADDR_CTRL, rd);
            check_eq(rd, 32'd2, "done once the draw ends");
            colour = (tbl_shape[i].rect.kind == KIND_CLEAR) ? 2'd0 : tbl_shape[i].rect.colour;
            scan_and_check(pal[colour], hits);
            check_eq(hits, tbl_count[i], {tbl_name[i], " pixel count"});
            apb_read(`PRU_ADDR_CTRL, rd);
            check_eq(rd, 32'd2, "done held until the next start");
            report_test(tbl_name[i], errs);
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, test_fails, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired after %0d time units with tests still running", WATCHDOG);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* include/pru_settings.svh */
`ifndef PRU_SETTINGS_SVH
`define PRU_SETTINGS_SVH

// Grid geometry
`define PRU_GRID        32
`define PRU_LANES       4      // Also the column interleave
`define PRU_COORD_W     6      // Row, column and size fields, sign bit included

// Words per lane bank, GRID * GRID / LANES
`define PRU_BANK_DEPTH  256

// APB register map
`define PRU_ADDR_CTRL   8'h00
`define PRU_ADDR_SHAPE  8'h04
`define PRU_ADDR_ORIGIN 8'h08  // Column in [5:0], row in [13:8]
`define PRU_ADDR_PAL0   8'h10
`define PRU_ADDR_PAL1   8'h14
`define PRU_ADDR_PAL2   8'h18
`define PRU_ADDR_PAL3   8'h1C

`endif

/* rtl/pru_apb_regs.sv */
`default_nettype none

`include "pru_settings.svh"

module pru_apb_regs
    import pru_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     i_psel,
    input  wire logic                     i_penable,
    input  wire logic                     i_pwrite,
    input  wire logic [7:0]               i_paddr,
    input  wire logic [31:0]              i_pwdata,
    input  wire logic [`PRU_LANES-1:0]    i_lanes_done,
    output logic      [31:0]              o_prdata,
    output logic                          o_pslverr,
    output pru_shape_u                    o_shape,
    output logic      [`PRU_COORD_W-1:0]  o_row,
    output logic      [`PRU_COORD_W-1:0]  o_col,
    output logic                          o_go,
    output logic                          o_lane_ack,
    output logic      [29:0]              o_pal0,
    output logic      [29:0]              o_pal1,
    output logic      [29:0]              o_pal2,
    output logic      [29:0]              o_pal3
);

    localparam logic [29:0] PAL_GREY = {3{10'h200}};  // Mid grey on all channels

    pru_shape_u shape_q;
    logic       busy;
    logic       done;
    logic       init_q;     // Power-up clear still owed
    logic       mapped;
    logic       wr;
    logic       launch;

    assign wr     = i_psel & i_penable & i_pwrite & mapped;
    assign launch = !busy && (init_q || (wr && i_paddr == `PRU_ADDR_CTRL && i_pwdata[0]));

    assign o_lane_ack = busy & (&i_lanes_done);
    assign o_pslverr  = i_psel & i_penable & !mapped;

    // First walk after reset is always a clear
    always_comb begin
        o_shape = shape_q;
        if (init_q)
            o_shape.rect.kind = KIND_CLEAR;
    end

    always_comb begin
        mapped   = 1'b1;
        o_prdata = '0;
        case (i_paddr)
            `PRU_ADDR_CTRL:   o_prdata = {30'd0, done, busy};
            `PRU_ADDR_SHAPE:  o_prdata = shape_q;
            `PRU_ADDR_ORIGIN: o_prdata = (32'(o_row) << 8) | 32'(o_col);
            `PRU_ADDR_PAL0:   o_prdata = 32'(o_pal0);
            `PRU_ADDR_PAL1:   o_prdata = 32'(o_pal1);
            `PRU_ADDR_PAL2:   o_prdata = 32'(o_pal2);
            `PRU_ADDR_PAL3:   o_prdata = 32'(o_pal3);
            default:          mapped = 1'b0;
        endcase
    end

    // Draw control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            init_q <= 1'b1;
            o_go   <= 1'b0;
        end else begin
            o_go <= launch;
            if (launch) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (o_lane_ack) begin
                busy   <= 1'b0;
                done   <= !init_q;  // Power-up clear leaves done low
                init_q <= 1'b0;
            end
        end
    end

    // Shape and origin stay frozen while the lanes walk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shape_q <= '0;
            o_row   <= '0;
            o_col   <= '0;
            o_pal0  <= PAL_GREY;
            o_pal1  <= PAL_GREY;
            o_pal2  <= PAL_GREY;
            o_pal3  <= PAL_GREY;
        end else if (wr) begin
            case (i_paddr)
                `PRU_ADDR_SHAPE: if (!busy) shape_q <= i_pwdata;
                `PRU_ADDR_ORIGIN: begin
                    if (!busy) begin
                        o_col <= i_pwdata[`PRU_COORD_W-1:0];
                        o_row <= i_pwdata[8 +: `PRU_COORD_W];
                    end
                end
                `PRU_ADDR_PAL0: o_pal0 <= i_pwdata[29:0];
                `PRU_ADDR_PAL1: o_pal1 <= i_pwdata[29:0];
                `PRU_ADDR_PAL2: o_pal2 <= i_pwdata[29:0];
                `PRU_ADDR_PAL3: o_pal3 <= i_pwdata[29:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/pru_pkg.sv */
`default_nettype none

`include "pru_settings.svh"

package pru_pkg;

    typedef enum logic [1:0] {
        KIND_RECT   = 2'd0,
        KIND_CIRCLE = 2'd1,
        KIND_CLEAR  = 2'd2  // Writes colour 0 over the whole grid
    } pru_kind_e;

    // Shape word, read as a rectangle or as a circle
    // Colour and kind sit in the low bits of both views
    typedef union packed {
        struct packed {
            logic [31-4-2*`PRU_COORD_W:0] pad;
            logic [`PRU_COORD_W-1:0]      width;
            logic [`PRU_COORD_W-1:0]      height;
            pru_kind_e                    kind;
            logic [1:0]                   colour;
        } rect;
        struct packed {
            logic [31-4-`PRU_COORD_W:0]   pad;
            logic [`PRU_COORD_W-1:0]      radius;
            pru_kind_e                    kind;
            logic [1:0]                   colour;
        } circ;
    } pru_shape_u;

    typedef enum logic [1:0] {
        LS_IDLE = 2'd0,
        LS_WALK = 2'd1,
        LS_DONE = 2'd2
    } pru_lane_state_e;

endpackage

`default_nettype wire

/* rtl/pru_raster_lane.sv */
`default_nettype none

`include "pru_settings.svh"

module pru_raster_lane
    import pru_pkg::*;
#(
    parameter int LANE_IDX = 0
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire pru_shape_u               i_shape,
    input  wire logic [`PRU_COORD_W-1:0]  i_row,
    input  wire logic [`PRU_COORD_W-1:0]  i_col,
    input  wire logic                     i_go,
    input  wire logic                     i_ack,
    input  wire logic [7:0]               i_rd_addr,
    output logic                          o_lane_done,
    output logic      [1:0]               o_rd_data
);

    localparam int W    = `PRU_COORD_W + 2;       // Room for origin plus size
    localparam int LAST = `PRU_GRID - 1;
    localparam int RW   = $clog2(`PRU_GRID);

    pru_lane_state_e     state;
    logic signed [W-1:0] row0, col0, size_h, size_w, rad;
    logic signed [W-1:0] raw_top, raw_bot, raw_left, raw_right;
    logic signed [W-1:0] top, bottom, left, right, first_col;
    logic signed [W-1:0] cur_row, cur_col;
    logic signed [W-1:0] dr, dc;
    logic signed [2*W-1:0] dist2, rad2;
    logic [1:0]          lane_off;
    logic                empty, in_grid, covered, wr_en;
    logic [1:0]          wr_colour;
    logic [1:0]          bank [`PRU_BANK_DEPTH];

    assign row0   = W'($signed(i_row));
    assign col0   = W'($signed(i_col));
    assign size_h = W'(i_shape.rect.height);
    assign size_w = W'(i_shape.rect.width);
    assign rad    = W'(i_shape.circ.radius);

    // Bounding box of the shape before clipping
    always_comb begin
        case (i_shape.rect.kind)
            KIND_RECT: begin
                raw_top   = row0;
                raw_bot   = row0 + size_h - 1;
                raw_left  = col0;
                raw_right = col0 + size_w - 1;
            end
            KIND_CIRCLE: begin
                raw_top   = row0 - rad;
                raw_bot   = row0 + rad;
                raw_left  = col0 - rad;
                raw_right = col0 + rad;
            end
            KIND_CLEAR: begin
                raw_top   = '0;
                raw_bot   = W'(LAST);
                raw_left  = '0;
                raw_right = W'(LAST);
            end
            default: begin  // Unused kind draws nothing
                raw_top   = '0;
                raw_bot   = '1;
                raw_left  = '0;
                raw_right = '1;
            end
        endcase
    end

    // Clip to the grid, then find this lane's first column
    assign top       = (raw_top < 0) ? '0 : raw_top;
    assign bottom    = (raw_bot > LAST) ? W'(LAST) : raw_bot;
    assign left      = (raw_left < 0) ? '0 : raw_left;
    assign right     = (raw_right > LAST) ? W'(LAST) : raw_right;
    assign lane_off  = 2'(LANE_IDX) - left[1:0];
    assign first_col = left + W'(lane_off);
    assign empty     = (top > bottom) || (first_col > right);

    assign dr    = cur_row - row0;
    assign dc    = cur_col - col0;
    assign dist2 = dr * dr + dc * dc;
    assign rad2  = rad * rad;

    assign in_grid = cur_row >= 0 && cur_row <= LAST && cur_col >= 0 && cur_col <= LAST;

    always_comb begin
        case (i_shape.rect.kind)
            KIND_RECT:   covered = cur_row >= raw_top && cur_row <= raw_bot &&
                                   cur_col >= raw_left && cur_col <= raw_right;
            KIND_CIRCLE: covered = dist2 <= rad2;
            KIND_CLEAR:  covered = 1'b1;
            default:     covered = 1'b0;
        endcase
    end

    assign wr_en       = (state == LS_WALK) && in_grid && covered;
    assign wr_colour   = (i_shape.rect.kind == KIND_CLEAR) ? 2'd0 : i_shape.rect.colour;
    assign o_lane_done = (state == LS_DONE);

    // Walk the box row by row, one owned column per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= LS_IDLE;
            cur_row <= '0;
            cur_col <= '0;
        end else begin
            case (state)
                LS_IDLE: begin
                    if (i_go) begin
                        cur_row <= top;
                        cur_col <= first_col;
                        state   <= empty ? LS_DONE : LS_WALK;
                    end
                end
                LS_WALK: begin
                    if (cur_col + `PRU_LANES <= right) begin
                        cur_col <= cur_col + `PRU_LANES;
                    end else if (cur_row < bottom) begin
                        cur_row <= cur_row + 1;
                        cur_col <= first_col;
                    end else begin
                        state <= LS_DONE;
                    end
                end
                LS_DONE: if (i_ack) state <= LS_IDLE;
                default: state <= LS_IDLE;
            endcase
        end
    end

    // Bank word holds row * 8 + column / 4
    always_ff @(posedge clk) begin
        if (wr_en)
            bank[{cur_row[RW-1:0], cur_col[RW-1:2]}] <= wr_colour;
        o_rd_data <= bank[i_rd_addr];
    end

endmodule

`default_nettype wire

/* rtl/pru_scanout.sv */
`default_nettype none

`include "pru_settings.svh"

module pru_scanout (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        i_scan_start,
    input  wire logic        i_pix_ready,
    input  wire logic [1:0]  i_rd_data0,
    input  wire logic [1:0]  i_rd_data1,
    input  wire logic [1:0]  i_rd_data2,
    input  wire logic [1:0]  i_rd_data3,
    input  wire logic [29:0] i_pal0,
    input  wire logic [29:0] i_pal1,
    input  wire logic [29:0] i_pal2,
    input  wire logic [29:0] i_pal3,
    output logic      [7:0]  o_rd_addr,
    output logic             o_pix_valid,
    output logic             o_pix_last,
    output logic      [9:0]  o_red,
    output logic      [9:0]  o_green,
    output logic      [9:0]  o_blue
);

    localparam int NPIX = `PRU_GRID * `PRU_GRID;
    localparam int CW   = $clog2(NPIX);
    localparam int SW   = $clog2(`PRU_LANES);

    logic [CW-1:0] cnt;         // Raster position, row in the high bits
    logic          running;
    logic          issue;
    logic          out_free;
    logic          s1_v, s1_last, skid_v, skid_last;
    logic [SW-1:0] s1_sel;
    logic [1:0]    idx;
    logic [29:0]   s1_rgb, skid_rgb;

    assign o_rd_addr = cnt[CW-1:SW];    // Column / 4 packed under the row
    assign out_free  = !o_pix_valid || i_pix_ready;
    // Only read when the word coming back has a place to land
    assign issue     = running && !skid_v && !(s1_v && !out_free);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (!running) begin
            if (i_scan_start) begin
                running <= 1'b1;
                cnt     <= '0;
            end
        end else if (issue) begin
            cnt <= cnt + 1'b1;
            if (cnt == CW'(NPIX - 1))
                running <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_v    <= 1'b0;
            s1_last <= 1'b0;
        end else begin
            s1_v    <= issue;
            s1_last <= issue && cnt == CW'(NPIX - 1);
        end
    end

    always_ff @(posedge clk)
        s1_sel <= cnt[SW-1:0];

    // Lane pick, then palette
    always_comb begin
        case (s1_sel)
            2'd0:    idx = i_rd_data0;
            2'd1:    idx = i_rd_data1;
            2'd2:    idx = i_rd_data2;
            default: idx = i_rd_data3;
        endcase
        case (idx)
            2'd0:    s1_rgb = i_pal0;
            2'd1:    s1_rgb = i_pal1;
            2'd2:    s1_rgb = i_pal2;
            default: s1_rgb = i_pal3;
        endcase
    end

    // Output register with a one-entry skid behind it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pix_valid <= 1'b0;
            o_pix_last  <= 1'b0;
            skid_v      <= 1'b0;
            skid_last   <= 1'b0;
        end else if (out_free) begin
            if (skid_v) begin
                o_pix_valid <= 1'b1;
                o_pix_last  <= skid_last;
                skid_v      <= 1'b0;
            end else begin
                o_pix_valid <= s1_v;
                o_pix_last  <= s1_v && s1_last;
            end
        end else if (s1_v) begin
            skid_v    <= 1'b1;
            skid_last <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_v)
                {o_red, o_green, o_blue} <= skid_rgb;
            else if (s1_v)
                {o_red, o_green, o_blue} <= s1_rgb;
        end else if (s1_v) begin
            skid_rgb <= s1_rgb;
        end
    end

endmodule

`default_nettype wire

/* rtl/pru_top.sv */
`default_nettype none

`include "pru_settings.svh"

module pru_top
    import pru_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        i_psel,
    input  wire logic        i_penable,
    input  wire logic        i_pwrite,
    input  wire logic [7:0]  i_paddr,
    input  wire logic [31:0] i_pwdata,
    output logic      [31:0] o_prdata,
    output logic             o_pslverr,
    input  wire logic        i_scan_start,
    output logic             o_pix_valid,
    input  wire logic        i_pix_ready,
    output logic             o_pix_last,
    output logic      [9:0]  o_red,
    output logic      [9:0]  o_green,
    output logic      [9:0]  o_blue
);

    pru_shape_u                shape;
    logic [`PRU_COORD_W-1:0]   row;
    logic [`PRU_COORD_W-1:0]   col;
    logic                      go;
    logic                      lane_ack;
    logic [`PRU_LANES-1:0]     lanes_done;
    logic [29:0]               pal0, pal1, pal2, pal3;
    logic [7:0]                rd_addr;
    logic [1:0]                rd_data [`PRU_LANES];

    pru_apb_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .i_lanes_done (lanes_done),
        .o_prdata     (o_prdata),
        .o_pslverr    (o_pslverr),
        .o_shape      (shape),
        .o_row        (row),
        .o_col        (col),
        .o_go         (go),
        .o_lane_ack   (lane_ack),
        .o_pal0       (pal0),
        .o_pal1       (pal1),
        .o_pal2       (pal2),
        .o_pal3       (pal3)
    );

    // Lane k owns columns k, k+4, k+8 ...
    for (genvar k = 0; k < `PRU_LANES; k++) begin : g_lane
        pru_raster_lane #(.LANE_IDX(k)) u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .i_shape     (shape),
            .i_row       (row),
            .i_col       (col),
            .i_go        (go),
            .i_ack       (lane_ack),
            .i_rd_addr   (rd_addr),
            .o_lane_done (lanes_done[k]),
            .o_rd_data   (rd_data[k])
        );
    end

    pru_scanout u_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_scan_start (i_scan_start),
        .i_pix_ready  (i_pix_ready),
        .i_rd_data0   (rd_data[0]),
        .i_rd_data1   (rd_data[1]),
        .i_rd_data2   (rd_data[2]),
        .i_rd_data3   (rd_data[3]),
        .i_pal0       (pal0),
        .i_pal1       (pal1),
        .i_pal2       (pal2),
        .i_pal3       (pal3),
        .o_rd_addr    (rd_addr),
        .o_pix_valid  (o_pix_valid),
        .o_pix_last   (o_pix_last),
        .o_red        (o_red),
        .o_green      (o_green),
        .o_blue       (o_blue)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the pixel rendering unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module pru_tb -Mdir obj_dir -o pru_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pru_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* sources.f */
+incdir+include
rtl/pru_pkg.sv
rtl/pru_apb_regs.sv
rtl/pru_raster_lane.sv
rtl/pru_scanout.sv
rtl/pru_top.sv
dv/pru_chk.sv
dv/pru_tb.sv
